// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := weight_rotator_tb
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/ram_if.sv
interface ram_if;

  logic                              req;
  logic                              we;
  logic [rot_pkg::addr_width-1:0]    addr;
  logic [rot_pkg::beat_width-1:0]    wdata;
  logic                              gnt;   // same cycle as req
  logic [rot_pkg::beat_width-1:0]    rdata; // one cycle after a granted read

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata
  );

endinterface

// File: common/rot_pkg.sv
package rot_pkg;

  //##################################################
  // sizes
  //##################################################

  localparam int word_width = 8;
  localparam int cores      = 2;
  localparam int kw_max     = 3;                      // kernel width
  localparam int beat_width = cores * kw_max * word_width;
  localparam int cin_max    = 8;
  localparam int depth_bank = 1 + 3 * cin_max;        // config beat + weights
  localparam int addr_width = $clog2(depth_bank) + 1; // top bit selects the bank

  localparam int cfg_bits = 17;

  //##################################################
  // packet config and output sideband
  //##################################################

  typedef struct packed {
    logic [beat_width-cfg_bits-1:0] pad;
    logic [3:0]                     blocks_1;
    logic [7:0]                     cols_1;
    logic [2:0]                     cin_1;
    logic [1:0]                     k_1;  // 0 or 2
  } rot_cfg_t;

  // first beat of a packet is read as cfg, the rest as data
  typedef union packed {
    logic [beat_width-1:0] data;
    rot_cfg_t              cfg;
  } rot_beat_u;

  typedef struct packed {
    logic is_1x1;
    logic is_cin_last;
    logic is_col_last;
  } rot_user_t;

endpackage

// File: files.f
common/rot_pkg.sv
common/ram_if.sv
weight_rotator/weight_writer.sv
weight_rotator/weight_reader.sv
weight_rotator/bank_arbiter.sv
weight_rotator/weight_ram.sv
src/weight_rotator_top.sv
tb/weight_rotator_tb.sv

// File: src/weight_rotator_top.sv
module weight_rotator_top #(
  parameter int cin_max = rot_pkg::cin_max,
  parameter int credits = 2
) (
  input  logic                           aclk,
  input  logic                           rst_n,
  input  logic [rot_pkg::beat_width-1:0] s_tdata,
  input  logic                           s_tvalid,
  output logic                           s_tready,
  input  logic                           s_tlast,
  output logic [rot_pkg::beat_width-1:0] m_tdata,
  output rot_pkg::rot_user_t             m_tuser,
  output logic                           m_tvalid,
  input  logic                           m_tready,
  output logic                           m_tlast
);

  logic [1:0] full;
  logic [1:0] bank_release;

  ram_if wr_if ();
  ram_if rd_if ();
  ram_if mem_if ();

  weight_writer #(.cin_max(cin_max)) u_writer (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .s_tdata      (s_tdata),
    .s_tvalid     (s_tvalid),
    .s_tlast      (s_tlast),
    .s_tready     (s_tready),
    .mem          (wr_if),
    .bank_release (bank_release),
    .full         (full)
  );

  weight_reader #(.credits(credits)) u_reader (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .mem          (rd_if),
    .full         (full),
    .bank_release (bank_release),
    .m_tdata      (m_tdata),
    .m_tuser      (m_tuser),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .m_tlast      (m_tlast)
  );

  bank_arbiter u_arbiter (
    .aclk  (aclk),
    .rst_n (rst_n),
    .wr    (wr_if),
    .rd    (rd_if),
    .mem   (mem_if)
  );

  weight_ram #(.cin_max(cin_max)) u_ram (
    .aclk (aclk),
    .mem  (mem_if)
  );

endmodule

// File: tb/weight_rotator_tb.sv
module weight_rotator_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_tests = 4;
  localparam int max_w   = 3 * rot_pkg::cin_max;
  localparam int bw      = rot_pkg::beat_width;

  typedef struct packed {
    logic [1:0] k_1;
    logic [2:0] cin_1;
    logic [7:0] cols_1;
    logic [3:0] blocks_1;
    logic       rand_ready;
  } stim_t;

  // k_1, cin_1, cols_1, blocks_1, random m_tready
  stim_t stim [n_tests] = '{
    '{2'd2, 3'd2, 8'd3, 4'd0, 1'b0},  // 3x3 over four columns
    '{2'd0, 3'd3, 8'd2, 4'd1, 1'b1},  // 1x1 with back-pressure
    '{2'd2, 3'd7, 8'd1, 4'd1, 1'b1},  // fills a whole bank
    '{2'd0, 3'd0, 8'd4, 4'd2, 1'b1}   // bank 1 a second time
  };
  string names [n_tests] = '{"conv3x3", "point1x1", "cin_max", "bank_reuse"};

  logic               aclk;
  logic               rst_n;
  logic [bw-1:0]      s_tdata;
  logic               s_tvalid;
  logic               s_tready;
  logic               s_tlast;
  logic [bw-1:0]      m_tdata;
  rot_pkg::rot_user_t m_tuser;
  logic               m_tvalid;
  logic               m_tready;
  logic               m_tlast;

  logic [bw-1:0] wts [n_tests][max_w]; // weight beats of each packet in input order
  logic [31:0]   lfsr_state;
  int            cycles;
  int            limit;

  weight_rotator_top #(.cin_max(rot_pkg::cin_max), .credits(2)) dut (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tuser  (m_tuser),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast)
  );

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;

  //##################################################
  // helpers
  //##################################################

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic rand_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  function automatic logic [bw-1:0] rand_beat();
    logic [bw-1:0] v;
    v = '0;
    for (int i = 0; i < bw; i++) begin
      v = {v[bw-2:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic int n_weights(input int p);
    return (int'(stim[p].k_1) + 1) * (int'(stim[p].cin_1) + 1);
  endfunction

  function automatic int n_out(input int p);
    return n_weights(p) * (int'(stim[p].cols_1) + 1) * (int'(stim[p].blocks_1) + 1);
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input rot_pkg::rot_beat_u exp,
                            input rot_pkg::rot_beat_u act);
    if (act.data !== exp.data) begin
      stop_on_error($sformatf("Mismatch %s m_tdata: expected %h, actual %h",
                              name, exp.data, act.data));
    end
  endtask

  task automatic check_user(input string name, input rot_pkg::rot_user_t exp,
                            input rot_pkg::rot_user_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch %s m_tuser: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_last(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch %s m_tlast: expected %b, actual %b", name, exp, act));
    end
  endtask

  //##################################################
  // input side
  //##################################################

  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge aclk);
      taken = s_tready; // beat moves on the coming edge
      @(posedge aclk);
    end
  endtask

  task automatic send_packet(input int p);
    rot_pkg::rot_beat_u cfg_beat;
    int                 nw;
    nw                    = n_weights(p);
    cfg_beat.data         = '0;
    cfg_beat.cfg.k_1      = stim[p].k_1;
    cfg_beat.cfg.cin_1    = stim[p].cin_1;
    cfg_beat.cfg.cols_1   = stim[p].cols_1;
    cfg_beat.cfg.blocks_1 = stim[p].blocks_1;
    for (int i = 0; i <= nw; i++) begin
      if (i == 0) begin
        s_tdata <= cfg_beat.data;
      end else begin
        s_tdata <= wts[p][i-1];
      end
      s_tvalid <= 1'b1;
      s_tlast  <= (i == nw);
      wait_accept();
    end
  endtask

  //##################################################
  // output side
  //##################################################

  task automatic take_beat(input logic rnd, output rot_pkg::rot_beat_u data,
                           output rot_pkg::rot_user_t user, output logic last);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(posedge aclk);
      m_tready <= rnd ? rand_bit() : 1'b1;
      @(negedge aclk);
      if (m_tvalid && m_tready) begin
        taken     = 1'b1;
        data.data = m_tdata;
        user      = m_tuser;
        last      = m_tlast;
      end
    end
  endtask

  task automatic check_packet(input int p);
    rot_pkg::rot_beat_u exp_data;
    rot_pkg::rot_beat_u act_data;
    rot_pkg::rot_user_t exp_user;
    rot_pkg::rot_user_t act_user;
    logic               act_last;
    logic               exp_last;
    string              name;
    int                 beat;
    int                 kh;
    int                 cin;
    int                 cols;
    int                 blks;
    kh   = int'(stim[p].k_1) + 1;
    cin  = int'(stim[p].cin_1) + 1;
    cols = int'(stim[p].cols_1) + 1;
    blks = int'(stim[p].blocks_1) + 1;
    beat = 0;
    // block, column, channel, kernel row
    for (int b = 0; b < blks; b++) begin
      for (int c = 0; c < cols; c++) begin
        for (int ch = 0; ch < cin; ch++) begin
          for (int r = 0; r < kh; r++) begin
            take_beat(stim[p].rand_ready, act_data, act_user, act_last);
            exp_data.data        = wts[p][ch * kh + r];
            exp_user.is_1x1      = (kh == 1);
            exp_user.is_cin_last = (ch == cin - 1);
            exp_user.is_col_last = (c == cols - 1);
            exp_last = (b == blks - 1) && (c == cols - 1) && (ch == cin - 1) && (r == kh - 1);
            name = $sformatf("%s beat %0d", names[p], beat);
            check_data(name, exp_data, act_data);
            check_user(name, exp_user, act_user);
            check_last(name, exp_last, act_last);
            beat++;
          end
        end
      end
    end
  endtask

  //##################################################
  // run
  //##################################################

  initial begin
    rst_n      = 1'b0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    m_tready   = 1'b0;
    lfsr_state = 32'hd08a_dded;
    cycles     = 0;
    limit      = 200;
    for (int p = 0; p < n_tests; p++) begin
      for (int i = 0; i < n_weights(p); i++) begin
        wts[p][i] = rand_beat();
      end
      limit += 4 * (n_out(p) + n_weights(p) + 1); // output beats plus input beats
    end
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;
    for (int p = 0; p < n_tests; p++) begin
      send_packet(p);
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
  end

  initial begin
    wait (rst_n === 1'b1);
    for (int p = 0; p < n_tests; p++) begin
      check_packet(p);
    end
    @(posedge aclk);
    m_tready <= 1'b1;
    repeat (20) begin
      @(negedge aclk);
      if (m_tvalid) stop_on_error("extra output beat after the final packet");
    end
    $display("TEST PASSED");
    $finish;
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles > limit) stop_on_error("timeout, output stalled");
  end

endmodule

// File: weight_rotator/bank_arbiter.sv
module bank_arbiter (
  input  logic     aclk,
  input  logic     rst_n,
  ram_if.arbiter   wr,
  ram_if.arbiter   rd,
  ram_if.requester mem
);

  logic prio_rd; // reader wins the next contested cycle
  logic sel_wr;
  logic gnt_wr;
  logic gnt_rd;

  // selection does not look at mem.gnt, so the RAM may depend on we/addr
  assign sel_wr = wr.req && (!rd.req || !prio_rd);
  assign gnt_wr = mem.gnt && sel_wr;
  assign gnt_rd = mem.gnt && rd.req && !sel_wr;

  assign wr.gnt = gnt_wr;
  assign rd.gnt = gnt_rd;

  assign mem.req   = wr.req || rd.req;
  assign mem.we    = sel_wr ? wr.we : rd.we;
  assign mem.addr  = sel_wr ? wr.addr : rd.addr;
  assign mem.wdata = sel_wr ? wr.wdata : rd.wdata;

  assign rd.rdata = mem.rdata;
  assign wr.rdata = '0; // writer never reads

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      prio_rd <= 1'b0;
    end else if (gnt_wr) begin
      prio_rd <= 1'b1;
    end else if (gnt_rd) begin
      prio_rd <= 1'b0;
    end
  end

  a_one_grant: assert property (@(posedge aclk) disable iff (!rst_n)
    !(wr.gnt && rd.gnt));

endmodule

// File: weight_rotator/weight_ram.sv
module weight_ram #(
  parameter int cin_max = rot_pkg::cin_max
) (
  input logic    aclk,
  ram_if.arbiter mem
);

  localparam int depth     = 1 + 3 * cin_max;
  localparam int off_width = rot_pkg::addr_width - 1;
  localparam int idx_width = $clog2(2 * depth);

  logic [rot_pkg::beat_width-1:0] ram [2 * depth];
  logic [rot_pkg::beat_width-1:0] rdata_q;
  logic [off_width-1:0]           off;
  logic [idx_width-1:0]           idx;

  // bank 1 sits right after bank 0
  assign off = mem.addr[off_width-1:0];
  assign idx = mem.addr[rot_pkg::addr_width-1] ? idx_width'(depth) + idx_width'(off)
                                               : idx_width'(off);

  assign mem.gnt   = 1'b1;
  assign mem.rdata = rdata_q;

  always_ff @(posedge aclk) begin
    if (mem.req) begin
      if (mem.we) begin
        ram[idx] <= mem.wdata;
      end else begin
        rdata_q <= ram[idx]; // one cycle read latency
      end
    end
  end

endmodule

// File: weight_rotator/weight_reader.sv
module weight_reader #(
  parameter int credits = 2
) (
  input  logic                           aclk,
  input  logic                           rst_n,
  ram_if.requester                       mem,
  input  logic [1:0]                     full,
  output logic [1:0]                     bank_release,
  output logic [rot_pkg::beat_width-1:0] m_tdata,
  output rot_pkg::rot_user_t             m_tuser,
  output logic                           m_tvalid,
  input  logic                           m_tready,
  output logic                           m_tlast
);

  localparam int off_width = rot_pkg::addr_width - 1;
  localparam int cnt_width = $clog2(credits + 1);
  localparam int ptr_width = (credits > 1) ? $clog2(credits) : 1;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_cfg  = 2'd1; // config read issued
  localparam logic [1:0] st_wait = 2'd2; // config data on rdata
  localparam logic [1:0] st_run  = 2'd3;

  logic [1:0]           state;
  logic                 bank;
  rot_pkg::rot_cfg_t    cfg;
  rot_pkg::rot_beat_u   rd_word;
  logic [off_width-1:0] off;
  logic [off_width-1:0] rd_off;
  logic [1:0]           row;
  logic [2:0]           ch;
  logic [7:0]           col;
  logic [3:0]           blk;
  logic [cnt_width-1:0] credit;
  logic                 rd_go;
  logic                 last_row;
  logic                 last_ch;
  logic                 last_col;
  logic                 last_all;
  logic                 pop;
  rot_pkg::rot_user_t   cur_user;
  logic                 tag_vld;
  logic                 tag_last;
  rot_pkg::rot_user_t   tag_user;

  logic [rot_pkg::beat_width-1:0] fifo_data [credits];
  rot_pkg::rot_user_t             fifo_user [credits];
  logic                           fifo_last [credits];
  logic [ptr_width-1:0]           wr_ptr;
  logic [ptr_width-1:0]           rd_ptr;
  logic [cnt_width-1:0]           fifo_cnt;

  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] p);
    return (p == ptr_width'(credits - 1)) ? '0 : p + 1'b1;
  endfunction

  //##################################################
  // read side
  //##################################################

  assign rd_word   = mem.rdata;
  assign rd_off    = (state == st_run) ? off : '0;
  assign mem.req   = (state == st_cfg) || (state == st_run && credit != '0);
  assign mem.we    = 1'b0;
  assign mem.addr  = {bank, rd_off};
  assign mem.wdata = '0;
  assign rd_go     = mem.req && mem.gnt && state == st_run;

  assign last_row = row == cfg.k_1;
  assign last_ch  = ch == cfg.cin_1;
  assign last_col = col == cfg.cols_1;
  assign last_all = last_row && last_ch && last_col && blk == cfg.blocks_1;

  assign cur_user.is_1x1      = cfg.k_1 == '0;
  assign cur_user.is_cin_last = last_ch;
  assign cur_user.is_col_last = last_col;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state        <= st_idle;
      bank         <= 1'b0;
      bank_release <= 2'b00;
    end else begin
      bank_release <= 2'b00;
      case (state)
        st_idle: if (full[bank]) state <= st_cfg;
        st_cfg:  if (mem.gnt) state <= st_wait;
        st_wait: state <= st_run;
        default: begin
          if (rd_go && last_all) begin
            state              <= st_idle;
            bank               <= ~bank;
            bank_release[bank] <= 1'b1; // final read of this bank is done
          end
        end
      endcase
    end
  end

  // block / column / channel / row counters
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      off <= '0;
      row <= '0;
      ch  <= '0;
      col <= '0;
      blk <= '0;
    end else if (state == st_wait) begin
      off <= off_width'(1);
      row <= '0;
      ch  <= '0;
      col <= '0;
      blk <= '0;
    end else if (rd_go) begin
      off <= (last_row && last_ch) ? off_width'(1) : off + 1'b1; // replay the set
      if (!last_row) begin
        row <= row + 1'b1;
      end else begin
        row <= '0;
        if (!last_ch) begin
          ch <= ch + 1'b1;
        end else begin
          ch <= '0;
          if (!last_col) begin
            col <= col + 1'b1;
          end else begin
            col <= '0;
            blk <= blk + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (state == st_wait) cfg <= rd_word.cfg;
    tag_user <= cur_user;
    tag_last <= last_all;
  end

  //##################################################
  // credits and output FIFO
  //##################################################

  assign pop = m_tvalid && m_tready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      credit   <= cnt_width'(credits);
      tag_vld  <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      credit   <= credit - cnt_width'(rd_go) + cnt_width'(pop);
      tag_vld  <= rd_go;
      fifo_cnt <= fifo_cnt + cnt_width'(tag_vld) - cnt_width'(pop);
      if (tag_vld) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
    end
  end

  always_ff @(posedge aclk) begin
    if (tag_vld) begin
      fifo_data[wr_ptr] <= mem.rdata;
      fifo_user[wr_ptr] <= tag_user;
      fifo_last[wr_ptr] <= tag_last;
    end
  end

  assign m_tvalid = fifo_cnt != '0;
  assign m_tdata  = fifo_data[rd_ptr];
  assign m_tuser  = fifo_user[rd_ptr];
  assign m_tlast  = fifo_last[rd_ptr];

  a_credit_max: assert property (@(posedge aclk) disable iff (!rst_n)
    credit <= cnt_width'(credits));

  a_hold_data: assert property (@(posedge aclk) disable iff (!rst_n)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

// File: weight_rotator/weight_writer.sv
module weight_writer #(
  parameter int cin_max = rot_pkg::cin_max
) (
  input  logic               aclk,
  input  logic               rst_n,
  input  rot_pkg::rot_beat_u s_tdata,
  input  logic               s_tvalid,
  input  logic               s_tlast,
  output logic               s_tready,
  ram_if.requester           mem,
  input  logic [1:0]         bank_release,
  output logic [1:0]         full
);

  localparam int depth     = 1 + 3 * cin_max;
  localparam int off_width = rot_pkg::addr_width - 1;

  logic                 bank;     // bank being filled
  logic [off_width-1:0] off;
  logic [off_width-1:0] last_off; // offset of the final weight beat
  logic [off_width-1:0] n_row;
  logic [off_width-1:0] n_ch;
  logic                 wr_go;
  logic [1:0]           set_full;

  // beat counts taken from the config view of the first beat
  assign n_row = off_width'(s_tdata.cfg.k_1) + 1'b1;
  assign n_ch  = off_width'(s_tdata.cfg.cin_1) + 1'b1;

  assign mem.req   = s_tvalid && !full[bank];
  assign mem.we    = 1'b1;
  assign mem.addr  = {bank, off};
  assign mem.wdata = s_tdata;
  assign s_tready  = mem.gnt;

  assign wr_go    = mem.req && mem.gnt;
  assign set_full = (wr_go && s_tlast) ? (bank ? 2'b10 : 2'b01) : 2'b00;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      bank <= 1'b0;
      off  <= '0;
      full <= 2'b00;
    end else begin
      full <= (full | set_full) & ~bank_release;
      if (wr_go) begin
        if (s_tlast) begin
          bank <= ~bank; // next packet goes to the other bank
          off  <= '0;
        end else begin
          off <= off + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_go && off == '0) begin
      last_off <= n_row * n_ch;
    end
  end

  //##################################################
  // checks
  //##################################################

  // an accepted input beat always lands in a free bank
  a_no_write_full: assert property (@(posedge aclk) disable iff (!rst_n)
    s_tvalid && s_tready |-> !full[bank]);

  // tlast has to land on the beat count announced by the config
  a_tlast_count: assert property (@(posedge aclk) disable iff (!rst_n)
    wr_go && off != '0 |-> s_tlast == (off == last_off));

  a_in_bank: assert property (@(posedge aclk) disable iff (!rst_n)
    wr_go |-> int'(off) < depth);

endmodule
